// ==== hdl/alu_pkg.sv ====
`include "backend_defines.svh"

package alu_pkg;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SLT = 3'd6     // Signed compare
    } alu_op_t;

    // Second operand source
    typedef enum logic {
        SRC_REG = 1'b0,
        SRC_IMM = 1'b1
    } src_sel_t;

endpackage

// ==== hdl/backend_defines.svh ====
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Datapath word width
`define DATA_W 32

// Architectural register index width
`define REG_ADDR_W 5

// ALU operation code width
`define ALU_OP_W 3

// Lane B write-back select, one bit per source
`define WB_SEL_W 4

`endif

// ==== hdl/ex_mem_wb.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module ex_mem_wb
    import alu_pkg::*, writeback_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic [`DATA_W-1:0]     pc_a,
    input  logic [`DATA_W-1:0]     rdata_a1,
    input  logic [`DATA_W-1:0]     rdata_a2,
    input  logic [`REG_ADDR_W-1:0] raddr_a1,
    input  logic [`REG_ADDR_W-1:0] raddr_a2,
    input  logic [`DATA_W-1:0]     imm_a,
    input  alu_op_t                alu_op_a,
    input  src_sel_t               src_sel_a,
    input  logic                   ex_rf_we_a,
    input  logic [`REG_ADDR_W-1:0] ex_waddr_a,

    input  logic [`DATA_W-1:0]     pc_b,
    input  logic [`DATA_W-1:0]     rdata_b1,
    input  logic [`DATA_W-1:0]     rdata_b2,
    input  logic [`REG_ADDR_W-1:0] raddr_b1,
    input  logic [`REG_ADDR_W-1:0] raddr_b2,
    input  logic [`DATA_W-1:0]     imm_b,
    input  alu_op_t                alu_op_b,
    input  src_sel_t               src_sel_b,
    input  logic                   ex_rf_we_b,
    input  logic [`REG_ADDR_W-1:0] ex_waddr_b,
    input  wb_sel_t                wb_sel_b,
    input  logic                   mul_en,
    input  logic                   mul_signed,
    input  logic                   mem_we,

    input  logic                   mem_ready,
    input  logic [`DATA_W-1:0]     mem_rdata,
    output logic                   stall,
    output logic                   mem_rvalid,
    output logic                   mem_wvalid,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_wdata,

    output logic                   rf_we_a,
    output logic                   rf_we_b,
    output logic [`REG_ADDR_W-1:0] rf_waddr_a,
    output logic [`REG_ADDR_W-1:0] rf_waddr_b,
    output logic [`DATA_W-1:0]     rf_wdata_a,
    output logic [`DATA_W-1:0]     rf_wdata_b
);

    lane_a_t              ex_a, mem_a, wb_a;
    lane_b_t              ex_b, mem_b, wb_b_d, wb_b;
    logic [`DATA_W-1:0]   fwd_a1, fwd_a2, fwd_b1, fwd_b2;
    logic [`DATA_W-1:0]   alu_res_a, alu_res_b;
    logic [`DATA_W-1:0]   wdata_b;
    logic [2*`DATA_W-1:0] product;
    logic                 mul_busy;
    logic                 stall_mem;

    assign stall_mem = !mem_ready;    // Cache still busy with the MEM access
    assign stall     = stall_mem || mul_busy;

    operand_forward u_fwd (
        .rdata_a1 (rdata_a1), .rdata_a2 (rdata_a2),
        .rdata_b1 (rdata_b1), .rdata_b2 (rdata_b2),
        .raddr_a1 (raddr_a1), .raddr_a2 (raddr_a2),
        .raddr_b1 (raddr_b1), .raddr_b2 (raddr_b2),
        .mem_a    (mem_a),    .wb_a     (wb_a),
        .mem_b    (mem_b),    .wb_b     (wb_b),
        .fwd_a1   (fwd_a1),   .fwd_a2   (fwd_a2),
        .fwd_b1   (fwd_b1),   .fwd_b2   (fwd_b2)
    );

    lane_alu u_alu_a (
        .op1 (fwd_a1), .op2 (fwd_a2), .imm (imm_a),
        .src_sel (src_sel_a), .alu_op (alu_op_a), .result (alu_res_a)
    );

    lane_alu u_alu_b (
        .op1 (fwd_b1), .op2 (fwd_b2), .imm (imm_b),
        .src_sel (src_sel_b), .alu_op (alu_op_b), .result (alu_res_b)
    );

    mul_unit u_mul (
        .clk (clk), .arst_n (arst_n),
        .mul_en (mul_en), .mul_signed (mul_signed), .stall_mem (stall_mem),
        .x (fwd_b1), .y (fwd_b2),
        .mul_busy (mul_busy), .product (product)
    );

    assign ex_a   = '{rf_we: ex_rf_we_a, waddr: ex_waddr_a, result: alu_res_a};
    assign ex_b   = '{rf_we: ex_rf_we_b, waddr: ex_waddr_b, wb_sel: wb_sel_b,
                      result: alu_res_b};
    assign wb_b_d = '{rf_we: mem_b.rf_we, waddr: mem_b.waddr, wb_sel: mem_b.wb_sel,
                      result: wdata_b};

    // EX/MEM holds under stall, MEM/WB takes a bubble
    stage_reg #(.payload_t(lane_a_t)) u_ex_mem_a (
        .clk (clk), .arst_n (arst_n), .stall (stall), .d (ex_a), .bubble (1'b0), .q (mem_a)
    );
    stage_reg #(.payload_t(lane_b_t)) u_ex_mem_b (
        .clk (clk), .arst_n (arst_n), .stall (stall), .d (ex_b), .bubble (1'b0), .q (mem_b)
    );
    stage_reg #(.payload_t(lane_a_t)) u_mem_wb_a (
        .clk (clk), .arst_n (arst_n), .stall (stall), .d (mem_a), .bubble (1'b1), .q (wb_a)
    );
    stage_reg #(.payload_t(lane_b_t)) u_mem_wb_b (
        .clk (clk), .arst_n (arst_n), .stall (stall), .d (wb_b_d), .bubble (1'b1), .q (wb_b)
    );

    mem_writeback u_mem_wb (
        .clk (clk), .arst_n (arst_n), .stall (stall), .mem_ready (mem_ready),
        .mem_rdata (mem_rdata), .mem_b (mem_b), .product (product), .wdata_b (wdata_b)
    );

    // Memory traffic is lane B only
    assign mem_rvalid = wb_sel_b[WB_LOAD];
    assign mem_wvalid = mem_we;
    assign mem_addr   = alu_res_b;    // Base plus offset
    assign mem_wdata  = fwd_b2;

    assign rf_we_a    = wb_a.rf_we;
    assign rf_waddr_a = wb_a.waddr;
    assign rf_wdata_a = wb_a.result;
    assign rf_we_b    = wb_b.rf_we;
    assign rf_waddr_b = wb_b.waddr;
    assign rf_wdata_b = wb_b.result;

    // Issue stage must keep the bundle in EX steady until it is taken
    a_ex_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        stall |=> $stable({pc_a, pc_b, wb_sel_b, mem_we, mul_en})
    );

endmodule

// ==== hdl/lane_alu.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module lane_alu
    import alu_pkg::*;
(
    input  logic [`DATA_W-1:0] op1,
    input  logic [`DATA_W-1:0] op2,
    input  logic [`DATA_W-1:0] imm,
    input  src_sel_t           src_sel,
    input  alu_op_t            alu_op,
    output logic [`DATA_W-1:0] result
);

    localparam int SHAMT_W = $clog2(`DATA_W);

    logic [`DATA_W-1:0] op_b;
    logic               less;

    assign op_b = (src_sel == SRC_IMM) ? imm : op2;
    assign less = $signed(op1) < $signed(op_b);

    always_comb begin
        case (alu_op)
            ALU_ADD: result = op1 + op_b;
            ALU_SUB: result = op1 - op_b;
            ALU_AND: result = op1 & op_b;
            ALU_OR:  result = op1 | op_b;
            ALU_XOR: result = op1 ^ op_b;
            ALU_SLL: result = op1 << op_b[SHAMT_W-1:0];    // Low bits only
            ALU_SLT: result = {{(`DATA_W-1){1'b0}}, less};
            default: result = '0;    // Spare code
        endcase
    end

endmodule

// ==== hdl/mem_writeback.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module mem_writeback
    import writeback_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall,
    input  logic                 mem_ready,
    input  logic [`DATA_W-1:0]   mem_rdata,
    input  lane_b_t              mem_b,
    input  logic [2*`DATA_W-1:0] product,
    output logic [`DATA_W-1:0]   wdata_b
);

    logic               buf_full;
    logic [`DATA_W-1:0] rdata_buf;
    logic               capture;
    logic [`DATA_W-1:0] load_data;

    // Read data is valid for one cycle only; keep it while the pipeline is stalled
    assign capture = mem_b.wb_sel[WB_LOAD] && mem_ready && !buf_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_full <= 1'b0;
        end else if (!stall) begin
            buf_full <= 1'b0;    // Load leaves MEM
        end else if (capture) begin
            buf_full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (stall && capture) begin
            rdata_buf <= mem_rdata;
        end
    end

    assign load_data = buf_full ? rdata_buf : mem_rdata;

    assign wdata_b = ({`DATA_W{mem_b.wb_sel[WB_ALU]}}    & mem_b.result)
                   | ({`DATA_W{mem_b.wb_sel[WB_LOAD]}}   & load_data)
                   | ({`DATA_W{mem_b.wb_sel[WB_MUL_LO]}} & product[`DATA_W-1:0])
                   | ({`DATA_W{mem_b.wb_sel[WB_MUL_HI]}} & product[2*`DATA_W-1:`DATA_W]);

    a_wb_sel_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(mem_b.wb_sel)
    );

endmodule

// ==== hdl/mul_unit.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module mul_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mul_en,
    input  logic                   mul_signed,
    input  logic                   stall_mem,
    input  logic [`DATA_W-1:0]     x,
    input  logic [`DATA_W-1:0]     y,
    output logic                   mul_busy,
    output logic [2*`DATA_W-1:0]   product
);

    localparam int HALF = `DATA_W / 2;

    logic                        mul_second;    // Multiply is in its second EX cycle
    logic signed [`DATA_W:0]     xs;
    logic signed [`DATA_W:0]     ys;
    logic signed [2*`DATA_W-1:0] part_lo;
    logic signed [2*`DATA_W-1:0] part_hi;
    logic signed [2*`DATA_W-1:0] part_lo_q;
    logic signed [2*`DATA_W-1:0] part_hi_q;

    assign mul_busy = mul_en && !mul_second;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_second <= 1'b0;
        end else if (mul_busy) begin
            mul_second <= 1'b1;
        end else if (!stall_mem) begin
            mul_second <= 1'b0;    // EX advances
        end
    end

    // One extra bit makes signed and unsigned the same signed product
    assign xs = {mul_signed & x[`DATA_W-1], x};
    assign ys = {mul_signed & y[`DATA_W-1], y};

    assign part_lo = xs * $signed({1'b0, ys[HALF-1:0]});
    assign part_hi = (xs * $signed(ys[`DATA_W:HALF])) <<< HALF;

    // MEM may hold an older multiply while this one waits in EX
    always_ff @(posedge clk) begin
        if (!stall_mem && !mul_busy) begin
            part_lo_q <= part_lo;
            part_hi_q <= part_hi;
        end
    end

    assign product = part_lo_q + part_hi_q;

    a_busy_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) mul_busy |=> mul_en && !mul_busy
    );

endmodule

// ==== hdl/operand_forward.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module operand_forward
    import writeback_pkg::*;
(
    input  logic [`DATA_W-1:0]     rdata_a1,
    input  logic [`DATA_W-1:0]     rdata_a2,
    input  logic [`DATA_W-1:0]     rdata_b1,
    input  logic [`DATA_W-1:0]     rdata_b2,
    input  logic [`REG_ADDR_W-1:0] raddr_a1,
    input  logic [`REG_ADDR_W-1:0] raddr_a2,
    input  logic [`REG_ADDR_W-1:0] raddr_b1,
    input  logic [`REG_ADDR_W-1:0] raddr_b2,
    input  lane_a_t                mem_a,
    input  lane_a_t                wb_a,
    input  lane_b_t                mem_b,
    input  lane_b_t                wb_b,
    output logic [`DATA_W-1:0]     fwd_a1,
    output logic [`DATA_W-1:0]     fwd_a2,
    output logic [`DATA_W-1:0]     fwd_b1,
    output logic [`DATA_W-1:0]     fwd_b2
);

    // Youngest matching producer wins; lane B is younger than lane A in a bundle
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_ADDR_W-1:0] raddr,
        input logic [`DATA_W-1:0]     rdata
    );
        logic [`DATA_W-1:0] val;
        val = rdata;
        if (raddr != '0) begin    // r0 reads as its register file value
            if (mem_b.rf_we && mem_b.wb_sel[WB_ALU] && mem_b.waddr == raddr) begin
                val = mem_b.result;
            end else if (mem_a.rf_we && mem_a.waddr == raddr) begin
                val = mem_a.result;
            end else if (wb_b.rf_we && wb_b.waddr == raddr) begin
                val = wb_b.result;    // Already muxed write data
            end else if (wb_a.rf_we && wb_a.waddr == raddr) begin
                val = wb_a.result;
            end
        end
        return val;
    endfunction

    assign fwd_a1 = pick(raddr_a1, rdata_a1);
    assign fwd_a2 = pick(raddr_a2, rdata_a2);
    assign fwd_b1 = pick(raddr_b1, rdata_b1);
    assign fwd_b2 = pick(raddr_b2, rdata_b2);

endmodule

// ==== hdl/stage_reg.sv ====
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  payload_t d,
    input  logic     bubble,
    output payload_t q
);

    // A zero payload has rf_we and wb_sel low, so it writes nothing back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end else if (bubble) begin
            q <= '0;    // Insert bubble
        end
    end

endmodule

// ==== hdl/writeback_pkg.sv ====
`include "backend_defines.svh"

package writeback_pkg;

    typedef logic [`WB_SEL_W-1:0] wb_sel_t;    // One-hot, zero for a bubble

    // Bit positions inside wb_sel_t
    localparam int WB_ALU    = 0;
    localparam int WB_LOAD   = 1;
    localparam int WB_MUL_LO = 2;
    localparam int WB_MUL_HI = 3;

    typedef struct packed {
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`DATA_W-1:0]     result;
    } lane_a_t;

    typedef struct packed {
        logic                   rf_we;
        logic [`REG_ADDR_W-1:0] waddr;
        wb_sel_t                wb_sel;
        logic [`DATA_W-1:0]     result;    // ALU result in MEM, final data in WB
    } lane_b_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_ex_mem_wb -o sim_tb > build.log 2>&1 \
    && { ./obj_dir/sim_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "sim failed" sim.log \
    && grep -q "sim passed" sim.log \
    || { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    initial begin
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== tests/tb_ex_mem_wb.sv ====
`timescale 1ns/10ps
`include "backend_defines.svh"

module tb_ex_mem_wb
    import alu_pkg::*, writeback_pkg::*;
;
    localparam int N_BUNDLES = 400;
    localparam int K_ALU = 0, K_LOAD = 1, K_STORE = 2, K_MUL = 3, K_NOP = 4;

    logic clk, arst_n, stall, mem_rvalid, mem_wvalid, rf_we_a, rf_we_b;
    logic [31:0] pc_a, rdata_a1, rdata_a2, imm_a, pc_b, rdata_b1, rdata_b2, imm_b;
    logic [31:0] mem_rdata, mem_addr, mem_wdata, rf_wdata_a, rf_wdata_b;
    logic [4:0] raddr_a1, raddr_a2, raddr_b1, raddr_b2, ex_waddr_a, ex_waddr_b;
    logic [4:0] rf_waddr_a, rf_waddr_b, nx_ra1, nx_ra2, nx_rb1, nx_rb2, block_dest;
    alu_op_t alu_op_a, alu_op_b;
    src_sel_t src_sel_a, src_sel_b;
    wb_sel_t wb_sel_b;
    logic ex_rf_we_a, ex_rf_we_b, mul_en, mul_signed, mem_we, mem_ready;

    logic [31:0] lfsr = 32'h7cba717a;
    logic [31:0] regs [32];     // Updated at issue
    logic [31:0] cregs [32];    // Updated at write-back
    logic [31:0] mem_model [logic [31:0]];
    logic [36:0] qa [$], qb [$];
    logic [36:0] exp_a, exp_b;
    logic [31:0] cur_addr, cur_wdata, ld_val, pc;
    int cur_kind, ready_cnt, issued, cycles;
    bit mul_first, s_stall, prev_stall;

    tb_clock_gen clk_gen0 (.clk(clk), .arst_n(arst_n));
    ex_mem_wb dut0 (.*);

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] r;
        logic b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], b};
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (mem_model.exists(addr)) return mem_model[addr];
        return (addr * 32'h9e3779b1) ^ 32'h1b873593;    // Fill from the full address
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] x, y);
        case (op)
            3'd0: return x + y;
            3'd1: return x - y;
            3'd2: return x & y;
            3'd3: return x | y;
            3'd4: return x ^ y;
            3'd5: return x << y[4:0];
            default: return {31'b0, $signed(x) < $signed(y)};
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [63:0] got, exp);
        assert (got === exp) else stop_with_failure($sformatf(
            "Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic issue_bundle(input bit real_op);
        logic [4:0] ra1, ra2, wa, rb1, rb2, wb;
        logic [31:0] ia, ib, resa, resb, xb, yb;
        logic [2:0] opa, opb;
        logic [63:0] p;
        logic sa, sb, wea, web, sgn, hi;
        int k;
        ra1 = 5'(rnd(5));
        ra2 = 5'(rnd(5));
        wa  = 5'(rnd(5));
        rb1 = 5'(rnd(5));
        rb2 = 5'(rnd(5));
        wb  = 5'(rnd(5));
        opa = 3'(rnd(3));
        opb = 3'(rnd(3));
        sa  = rnd(1) != 0;
        sb  = rnd(1) != 0;
        ia  = rnd(32);
        ib  = rnd(32);
        wea = real_op && rnd(2) != 0;
        k = real_op ? int'(rnd(2)) : K_NOP;
        sgn = rnd(1) != 0;
        hi = rnd(1) != 0;
        if (ra1 == block_dest) ra1 = 0;    // No consumer right after a load or multiply
        if (ra2 == block_dest) ra2 = 0;
        if (rb1 == block_dest || (wea && rb1 == wa)) rb1 = 0;
        if (rb2 == block_dest || (wea && rb2 == wa)) rb2 = 0;
        if (k == K_LOAD || k == K_STORE) begin
            rb1 = 0;
            opb = 3'd0;
            sb  = 1'b1;
            ib  = {26'b0, 4'(rnd(4)), 2'b00};    // Small window so loads hit stores
        end
        if (opa == 3'd7) opa = 3'd0;
        if (opb == 3'd7) opb = 3'd0;
        web  = (k == K_LOAD || k == K_MUL) || (k == K_ALU && rnd(1) != 0);
        resa = alu_ref(opa, regs[ra1], sa ? ia : regs[ra2]);
        resb = alu_ref(opb, regs[rb1], sb ? ib : regs[rb2]);
        cur_addr  = resb;
        cur_wdata = regs[rb2];
        xb = regs[rb1];
        yb = regs[rb2];
        p = {{32{sgn & xb[31]}}, xb} * {{32{sgn & yb[31]}}, yb};
        if (k == K_LOAD) resb = mem_read(cur_addr);
        if (k == K_MUL) resb = hi ? p[63:32] : p[31:0];
        if (wea) qa.push_back({wa, resa});
        if (web) qb.push_back({wb, resb});
        if (wea && wa != 0) regs[wa] = resa;
        if (web && wb != 0) regs[wb] = resb;    // Lane B is younger
        block_dest = (k == K_LOAD || k == K_MUL) ? wb : 5'd0;
        mul_first  = (k == K_MUL);
        cur_kind   = k;
        if (real_op) issued++;
        nx_ra1 = ra1;
        nx_ra2 = ra2;
        nx_rb1 = rb1;
        nx_rb2 = rb2;
        pc_a <= pc;
        pc_b <= pc + 4;
        pc += 8;
        raddr_a1 <= ra1;
        raddr_a2 <= ra2;
        raddr_b1 <= rb1;
        raddr_b2 <= rb2;
        imm_a <= ia;
        imm_b <= ib;
        alu_op_a <= alu_op_t'(opa);
        alu_op_b <= alu_op_t'(opb);
        src_sel_a <= src_sel_t'(sa);
        src_sel_b <= src_sel_t'(sb);
        ex_rf_we_a <= wea;
        ex_waddr_a <= wa;
        ex_rf_we_b <= web;
        ex_waddr_b <= wb;
        wb_sel_b <= (k == K_ALU) ? 4'b0001 : (k == K_LOAD) ? 4'b0010 :
                    (k == K_MUL) ? (hi ? 4'b1000 : 4'b0100) : 4'b0000;
        mul_en     <= (k == K_MUL);
        mul_signed <= sgn;
        mem_we     <= (k == K_STORE);
    endtask

    // Cache model, then issue when EX advances, then register file read
    task automatic edge_step();
        int d;
        if (!s_stall && (cur_kind == K_LOAD || cur_kind == K_STORE)) begin
            if (cur_kind == K_STORE) mem_model[cur_addr] = cur_wdata;
            ld_val = mem_read(cur_addr);
            d = int'(rnd(2));
            if (d == 3) d = 0;
            ready_cnt = d;
            mem_ready <= (d == 0);
            mem_rdata <= ld_val;
        end else if (ready_cnt > 0) begin
            ready_cnt--;
            mem_ready <= (ready_cnt == 0);
            mem_rdata <= ld_val;
        end else begin
            mem_rdata <= ~ld_val;    // Stale data once the first ready cycle is over
        end
        mul_first = 1'b0;
        if (!s_stall) issue_bundle(issued < N_BUNDLES);
        rdata_a1 <= cregs[nx_ra1];
        rdata_a2 <= cregs[nx_ra2];
        rdata_b1 <= cregs[nx_rb1];
        rdata_b2 <= cregs[nx_rb2];
    endtask

    always @(negedge clk) begin
        if (arst_n) begin
            expect_equal("stall", stall, !mem_ready || mul_first);
            if (prev_stall) assert (!rf_we_a && !rf_we_b)
                else stop_with_failure("Write-back in the cycle after a stall");
            if (rf_we_a) begin
                assert (qa.size() > 0) else stop_with_failure("Unexpected lane A write-back");
                exp_a = qa.pop_front();
                expect_equal("rf_waddr_a", rf_waddr_a, exp_a[36:32]);
                expect_equal("rf_wdata_a", rf_wdata_a, exp_a[31:0]);
                if (rf_waddr_a != 0) cregs[rf_waddr_a] = rf_wdata_a;
            end
            if (rf_we_b) begin
                assert (qb.size() > 0) else stop_with_failure("Unexpected lane B write-back");
                exp_b = qb.pop_front();
                expect_equal("rf_waddr_b", rf_waddr_b, exp_b[36:32]);
                expect_equal("rf_wdata_b", rf_wdata_b, exp_b[31:0]);
                if (rf_waddr_b != 0) cregs[rf_waddr_b] = rf_wdata_b;
            end
            expect_equal("mem_rvalid", mem_rvalid, cur_kind == K_LOAD);
            expect_equal("mem_wvalid", mem_wvalid, cur_kind == K_STORE);
            if (cur_kind == K_LOAD || cur_kind == K_STORE) begin
                expect_equal("mem_addr", mem_addr, cur_addr);
            end
            if (cur_kind == K_STORE) expect_equal("mem_wdata", mem_wdata, cur_wdata);
            prev_stall = stall;
            s_stall    = stall;
        end
    end

    initial begin
        {pc_a, pc_b, rdata_a1, rdata_a2, rdata_b1, rdata_b2, imm_a, imm_b} = '0;
        {raddr_a1, raddr_a2, raddr_b1, raddr_b2, ex_waddr_a, ex_waddr_b} = '0;
        {ex_rf_we_a, ex_rf_we_b, mul_en, mul_signed, mem_we, wb_sel_b} = '0;
        alu_op_a  = ALU_ADD;
        alu_op_b  = ALU_ADD;
        src_sel_a = SRC_REG;
        src_sel_b = SRC_REG;
        mem_ready = 1'b1;
        mem_rdata = '0;
        {nx_ra1, nx_ra2, nx_rb1, nx_rb2, block_dest} = '0;
        cur_kind  = K_NOP;
        ready_cnt = 0;
        issued    = 0;
        pc        = 32'h1000;
        for (int i = 0; i < 32; i++) begin
            regs[i]  = (i == 0) ? 32'h0 : rnd(32);
            cregs[i] = regs[i];
        end
        cycles = 0;
        while (!arst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) stop_with_failure("Reset was never released");
        end
        cycles = 0;
        while (issued < N_BUNDLES || qa.size() != 0 || qb.size() != 0) begin
            @(posedge clk);
            edge_step();
            cycles++;
            if (cycles > 20 * N_BUNDLES) stop_with_failure("Timeout waiting for write-backs");
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/writeback_pkg.sv
hdl/operand_forward.sv
hdl/lane_alu.sv
hdl/mul_unit.sv
hdl/stage_reg.sv
hdl/mem_writeback.sv
hdl/ex_mem_wb.sv
tests/tb_clock_gen.sv
tests/tb_ex_mem_wb.sv
